// ==== design/uart_line_pkg.sv ====
// UART line timing and framing constants
// The bit period is a whole number of clk cycles
// Frames are 8N1 with no parity and no flow control

package uart_line_pkg;

  // Oversampling of one UART bit
  localparam int CLKS_PER_BIT = 16;
  localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);

  // 8N1 framing
  localparam int DATA_BITS = 8;

  typedef logic [DATA_BITS-1:0] byte_t;

endpackage

// ==== design/dbg_proto_pkg.sv ====
// Debug loader protocol definitions
// Multi-byte fields travel little endian on the line
// Only the low ADDR_W bits of address and length are kept
// Target memory is 2**MEM_AW bytes and the address wraps

package dbg_proto_pkg;

  ////////////////////
  // Opcodes and replies
  ////////////////////

  typedef enum logic [7:0] {
    CMD_READ  = 8'h11,
    CMD_WRITE = 8'h12,
    CMD_EXEC  = 8'h13
  } dbg_cmd_e;

  typedef enum logic [7:0] {
    REP_EOT = 8'h04,
    REP_ACK = 8'h06,
    REP_EOC = 8'h14
  } dbg_reply_e;

  ////////////////////
  // Field widths
  ////////////////////

  localparam int FIELD_BYTES = 8;
  localparam int ADDR_W      = 16;
  localparam int MEM_AW      = 8;
  localparam int EXIT_W      = 64;

  // Control unit sequencing
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_HEADER,
    ST_ACK,
    ST_DATA,
    ST_EOT,
    ST_EXEC_WAIT,
    ST_EOC,
    ST_EXIT
  } dbg_state_e;

endpackage

// ==== design/dbg_mem_if.sv ====
`timescale 1ns/100ps
// Byte-wide four-phase memory access channel
// The requester holds addr, we and wdata stable while req is high
// rdata is valid only while ack is high

interface dbg_mem_if;

  import dbg_proto_pkg::*;

  logic                 req;
  logic                 we;
  logic [MEM_AW-1:0]    addr;
  uart_line_pkg::byte_t wdata;
  logic                 ack;
  uart_line_pkg::byte_t rdata;

  // Requester side
  modport ctrl (
    output req, we, addr, wdata,
    input  ack, rdata
  );

  // Responder side
  modport mem (
    input  req, we, addr, wdata,
    output ack, rdata
  );

endinterface

// ==== design/uart_rx.sv ====
`timescale 1ns/100ps
// 8N1 UART receiver offering each byte over a four-phase req/ack
// rx_i is asynchronous and passes a two-flop synchronizer
// Sample points sit two cycles early to make up for the synchronizer
// A frame with a low stop bit is dropped
// A frame that ends while the previous byte is still in handshake is lost

module uart_rx (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 rx_i,
  output logic                 rx_req_o,
  output uart_line_pkg::byte_t rx_data_o,
  input  logic                 rx_ack_i
);

  import uart_line_pkg::*;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e                    state_q;
  logic [1:0]                   sync_q;
  logic                         rx_s;
  logic [BIT_CNT_W-1:0]         cnt_q;
  logic [$clog2(DATA_BITS)-1:0] bit_idx_q;
  byte_t                        shift_q;
  logic                         cnt_done;
  logic                         frame_ok;

  assign rx_s     = sync_q[1];
  assign cnt_done = (cnt_q == BIT_CNT_W'(CLKS_PER_BIT - 1));
  // Good stop bit and the byte channel is free
  assign frame_ok = (state_q == RX_STOP) && cnt_done && rx_s && !rx_req_o && !rx_ack_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      sync_q    <= 2'b11;
      state_q   <= RX_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      rx_req_o  <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], rx_i};
      cnt_q  <= cnt_q + 1'b1;
      if (rx_req_o && rx_ack_i) begin
        rx_req_o <= 1'b0;
      end
      case (state_q)
        RX_IDLE: begin
          cnt_q <= '0;
          if (!rx_s) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          // Middle of the start bit, a high line here was a glitch
          if (cnt_q == BIT_CNT_W'(CLKS_PER_BIT / 2 - 2)) begin
            cnt_q     <= '0;
            bit_idx_q <= '0;
            state_q   <= rx_s ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (cnt_done) begin
            cnt_q     <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (int'(bit_idx_q) == DATA_BITS - 1) begin
              state_q <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (cnt_done) begin
            cnt_q   <= '0;
            state_q <= RX_IDLE;
            if (frame_ok) begin
              rx_req_o <= 1'b1;
            end
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && cnt_done) begin
      shift_q <= {rx_s, shift_q[DATA_BITS-1:1]};
    end
    if (frame_ok) begin
      rx_data_o <= shift_q;
    end
  end

endmodule

// ==== design/uart_tx.sv ====
`timescale 1ns/100ps
// 8N1 UART transmitter taking one byte per four-phase req/ack
// tx_ack_o rises once the stop bit has been on the line a full bit time
// tx_data_i is sampled only in the cycle the request is seen

module uart_tx (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 tx_req_i,
  input  uart_line_pkg::byte_t tx_data_i,
  output logic                 tx_ack_o,
  output logic                 tx_o
);

  import uart_line_pkg::*;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_SEND,
    TX_DONE
  } tx_state_e;

  tx_state_e                        state_q;
  logic [BIT_CNT_W-1:0]             cnt_q;
  logic [$clog2(DATA_BITS + 2)-1:0] bit_idx_q;
  logic [DATA_BITS:0]               shift_q;
  logic                             cnt_done;
  logic                             load;

  assign cnt_done = (cnt_q == BIT_CNT_W'(CLKS_PER_BIT - 1));
  assign load     = (state_q == TX_IDLE) && tx_req_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q   <= TX_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      tx_ack_o  <= 1'b0;
      tx_o      <= 1'b1;
    end else begin
      case (state_q)
        TX_IDLE: begin
          if (load) begin
            // Start bit
            tx_o      <= 1'b0;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            state_q   <= TX_SEND;
          end
        end
        TX_SEND: begin
          cnt_q <= cnt_done ? '0 : cnt_q + 1'b1;
          if (cnt_done) begin
            if (int'(bit_idx_q) == DATA_BITS + 1) begin
              tx_ack_o <= 1'b1;
              state_q  <= TX_DONE;
            end else begin
              tx_o      <= shift_q[0];
              bit_idx_q <= bit_idx_q + 1'b1;
            end
          end
        end
        TX_DONE: begin
          if (!tx_req_i) begin
            tx_ack_o <= 1'b0;
            state_q  <= TX_IDLE;
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  // Data bits then stop bit, ones fill in behind
  always_ff @(posedge clk) begin
    if (load) begin
      shift_q <= {1'b1, tx_data_i};
    end else if (state_q == TX_SEND && cnt_done) begin
      shift_q <= {1'b1, shift_q[DATA_BITS:1]};
    end
  end

endmodule

// ==== design/dbg_mem.sv ====
`timescale 1ns/100ps
// Target memory of 2**MEM_AW bytes on the four-phase memory channel
// One access per handshake, ack follows req by one cycle
// Contents survive reset and start out unknown

module dbg_mem (
  input  logic   clk,
  input  logic   rst_n_i,
  dbg_mem_if.mem mem
);

  import dbg_proto_pkg::*;

  uart_line_pkg::byte_t mem_array [2**MEM_AW];
  logic                 access;

  // First cycle of a request
  assign access = mem.req && !mem.ack;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      mem.ack <= 1'b0;
    end else begin
      mem.ack <= mem.req;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      if (mem.we) begin
        mem_array[mem.addr] <= mem.wdata;
      end
      mem.rdata <= mem_array[mem.addr];
    end
  end

endmodule

// ==== design/dbg_ctrl.sv ====
`timescale 1ns/100ps
// Debug protocol control unit
// Handles the ACK challenge, READ, WRITE and EXEC from the host
// Unknown opcodes in idle are consumed without a reply
// Upper header bytes beyond ADDR_W are received and ignored
// The host must wait for each reply before it sends more

module dbg_ctrl (
  input  logic                               clk,
  input  logic                               rst_n_i,
  input  logic                               rx_req_i,
  input  uart_line_pkg::byte_t               rx_data_i,
  output logic                               rx_ack_o,
  output logic                               tx_req_o,
  output uart_line_pkg::byte_t               tx_data_o,
  input  logic                               tx_ack_i,
  dbg_mem_if.ctrl                            mem,
  output logic                               exec_req_o,
  output logic [dbg_proto_pkg::ADDR_W-1:0]   exec_addr_o,
  input  logic                               exec_ack_i,
  input  logic [dbg_proto_pkg::EXIT_W-1:0]   exit_code_i
);

  import dbg_proto_pkg::*;

  dbg_state_e                       state_q;
  dbg_cmd_e                         cmd_q;
  logic                             chal_q;
  logic [$clog2(2*FIELD_BYTES)-1:0] cnt_q;
  logic [ADDR_W-1:0]                addr_q;
  logic [ADDR_W-1:0]                len_q;
  logic [EXIT_W-1:0]                exit_q;
  logic [$clog2(FIELD_BYTES)-1:0]   byte_idx;
  logic                             last_hdr;
  logic                             rx_avail;
  logic                             tx_idle;
  logic                             tx_done;
  logic                             mem_idle;
  logic                             mem_done;

  ////////////////////
  // Handshake status
  ////////////////////

  assign rx_avail = rx_req_i && !rx_ack_o;
  assign tx_idle  = !tx_req_o && !tx_ack_i;
  assign tx_done  = tx_req_o && tx_ack_i;
  assign mem_idle = !mem.req && !mem.ack;
  assign mem_done = mem.req && mem.ack;

  // EXEC has one header field, READ and WRITE have two
  assign byte_idx = cnt_q[$clog2(FIELD_BYTES)-1:0];
  assign last_hdr = (cmd_q == CMD_EXEC) ? (int'(cnt_q) == FIELD_BYTES - 1)
                                        : (int'(cnt_q) == 2 * FIELD_BYTES - 1);

  assign exec_addr_o = addr_q;

  ////////////////////
  // Command FSM
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q    <= ST_IDLE;
      chal_q     <= 1'b0;
      cnt_q      <= '0;
      rx_ack_o   <= 1'b0;
      tx_req_o   <= 1'b0;
      mem.req    <= 1'b0;
      exec_req_o <= 1'b0;
    end else begin
      // Return to zero on every channel
      if (rx_ack_o && !rx_req_i) begin
        rx_ack_o <= 1'b0;
      end
      if (tx_done) begin
        tx_req_o <= 1'b0;
      end
      if (mem_done) begin
        mem.req <= 1'b0;
      end

      case (state_q)
        ST_IDLE: begin
          if (rx_avail) begin
            rx_ack_o <= 1'b1;
            cnt_q    <= '0;
            chal_q   <= 1'b0;
            case (rx_data_i)
              CMD_READ, CMD_WRITE, CMD_EXEC: begin
                cmd_q   <= dbg_cmd_e'(rx_data_i);
                state_q <= ST_HEADER;
              end
              REP_ACK: begin
                chal_q  <= 1'b1;
                state_q <= ST_ACK;
              end
              default: state_q <= ST_IDLE;
            endcase
          end
        end
        ST_HEADER: begin
          if (rx_avail) begin
            rx_ack_o <= 1'b1;
            cnt_q    <= cnt_q + 1'b1;
            // Low bytes shift in from the top
            if (int'(byte_idx) < ADDR_W / 8) begin
              if (int'(cnt_q) < FIELD_BYTES) begin
                addr_q <= {rx_data_i, addr_q[ADDR_W-1:8]};
              end else begin
                len_q <= {rx_data_i, len_q[ADDR_W-1:8]};
              end
            end
            if (last_hdr) begin
              state_q <= ST_ACK;
            end
          end
        end
        ST_ACK: begin
          if (tx_idle) begin
            tx_req_o  <= 1'b1;
            tx_data_o <= REP_ACK;
          end
          if (tx_done) begin
            if (chal_q) begin
              state_q <= ST_IDLE;
            end else if (cmd_q == CMD_EXEC) begin
              exec_req_o <= 1'b1;
              state_q    <= ST_EXEC_WAIT;
            end else begin
              state_q <= (len_q == '0) ? ST_EOT : ST_DATA;
            end
          end
        end
        ST_DATA: begin
          if (cmd_q == CMD_WRITE) begin
            if (rx_avail && mem_idle) begin
              rx_ack_o  <= 1'b1;
              mem.req   <= 1'b1;
              mem.we    <= 1'b1;
              mem.addr  <= addr_q[MEM_AW-1:0];
              mem.wdata <= rx_data_i;
            end
          end else if (mem_idle && tx_idle) begin
            mem.req  <= 1'b1;
            mem.we   <= 1'b0;
            mem.addr <= addr_q[MEM_AW-1:0];
          end
          // Read data goes straight to the transmitter
          if (mem_done && cmd_q == CMD_READ) begin
            tx_req_o  <= 1'b1;
            tx_data_o <= mem.rdata;
          end
          if ((cmd_q == CMD_WRITE) ? mem_done : tx_done) begin
            addr_q <= addr_q + 1'b1;
            len_q  <= len_q - 1'b1;
            if (len_q == ADDR_W'(1)) begin
              state_q <= ST_EOT;
            end
          end
        end
        ST_EOT: begin
          if (tx_idle) begin
            tx_req_o  <= 1'b1;
            tx_data_o <= REP_EOT;
          end
          if (tx_done) begin
            state_q <= ST_IDLE;
          end
        end
        ST_EXEC_WAIT: begin
          if (exec_ack_i) begin
            exec_req_o <= 1'b0;
            exit_q     <= exit_code_i;
            state_q    <= ST_EOC;
          end
        end
        ST_EOC: begin
          if (tx_idle) begin
            tx_req_o  <= 1'b1;
            tx_data_o <= REP_EOC;
          end
          if (tx_done) begin
            cnt_q   <= '0;
            state_q <= ST_EXIT;
          end
        end
        ST_EXIT: begin
          // Exit code LSB first
          if (tx_idle) begin
            tx_req_o  <= 1'b1;
            tx_data_o <= exit_q[7:0];
          end
          if (tx_done) begin
            exit_q <= exit_q >> 8;
            cnt_q  <= cnt_q + 1'b1;
            if (int'(cnt_q) == EXIT_W / 8 - 1) begin
              state_q <= ST_IDLE;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== design/uart_dbg_top.sv ====
`timescale 1ns/100ps
// UART debug loader top level
// Line rate is clk / uart_line_pkg::CLKS_PER_BIT
// exec_ack_i must return low before the next EXEC command
// uart_tx_o idles high from reset

module uart_dbg_top (
  input  logic                             clk,
  input  logic                             rst_n_i,
  input  logic                             uart_rx_i,
  output logic                             uart_tx_o,
  output logic                             exec_req_o,
  output logic [dbg_proto_pkg::ADDR_W-1:0] exec_addr_o,
  input  logic                             exec_ack_i,
  input  logic [dbg_proto_pkg::EXIT_W-1:0] exit_code_i
);

  import uart_line_pkg::*;

  logic  rx_req;
  logic  rx_ack;
  byte_t rx_data;
  logic  tx_req;
  logic  tx_ack;
  byte_t tx_data;

  dbg_mem_if mem_bus ();

  ////////////////////
  // Line side
  ////////////////////

  uart_rx uart_rx_inst (
    .clk       ( clk       ),
    .rst_n_i   ( rst_n_i   ),
    .rx_i      ( uart_rx_i ),
    .rx_req_o  ( rx_req    ),
    .rx_data_o ( rx_data   ),
    .rx_ack_i  ( rx_ack    )
  );

  uart_tx uart_tx_inst (
    .clk       ( clk       ),
    .rst_n_i   ( rst_n_i   ),
    .tx_req_i  ( tx_req    ),
    .tx_data_i ( tx_data   ),
    .tx_ack_o  ( tx_ack    ),
    .tx_o      ( uart_tx_o )
  );

  ////////////////////
  // Protocol and storage
  ////////////////////

  dbg_ctrl dbg_ctrl_inst (
    .clk         ( clk         ),
    .rst_n_i     ( rst_n_i     ),
    .rx_req_i    ( rx_req      ),
    .rx_data_i   ( rx_data     ),
    .rx_ack_o    ( rx_ack      ),
    .tx_req_o    ( tx_req      ),
    .tx_data_o   ( tx_data     ),
    .tx_ack_i    ( tx_ack      ),
    .mem         ( mem_bus     ),
    .exec_req_o  ( exec_req_o  ),
    .exec_addr_o ( exec_addr_o ),
    .exec_ack_i  ( exec_ack_i  ),
    .exit_code_i ( exit_code_i )
  );

  dbg_mem dbg_mem_inst (
    .clk     ( clk     ),
    .rst_n_i ( rst_n_i ),
    .mem     ( mem_bus )
  );

endmodule

// ==== dv/tb_uart_dbg.sv ====
`timescale 1ns/100ps
// Testbench for the UART debug loader, acting as the host
// Host waits for every reply before it sends again
// Host bytes are spaced by one idle bit after the stop bit
// Reads only cover addresses that an earlier write filled
// Stops at the first error

module tb_uart_dbg;

  import uart_line_pkg::*;
  import dbg_proto_pkg::*;

  localparam int FRAME_CYCLES = (DATA_BITS + 2) * CLKS_PER_BIT;
  localparam int NUM_RW_RUNS  = 3;
  localparam int MAX_LEN      = 16;

  ////////////////////
  // Timeout budget in frames
  ////////////////////

  localparam int HDR_FRAMES   = 1 + 2 * FIELD_BYTES;
  localparam int RW_FRAMES    = NUM_RW_RUNS * 2 * (HDR_FRAMES + MAX_LEN + 2);
  localparam int ZERO_FRAMES  = 2 * (HDR_FRAMES + 2);
  localparam int EXEC_FRAMES  = 1 + FIELD_BYTES + 2 + EXIT_W / 8;
  // Idle start, challenge with quiet time, unknown opcode with quiet time and challenge
  localparam int MISC_FRAMES  = 2 + 3 + 5;
  localparam int TOTAL_FRAMES = RW_FRAMES + ZERO_FRAMES + EXEC_FRAMES + MISC_FRAMES;
  localparam int TIMEOUT_CYCLES = 2 * (TOTAL_FRAMES * 10 * CLKS_PER_BIT) + 1000;

  logic              clk;
  logic              rst_n_i;
  logic              uart_rx_i;
  logic              uart_tx_o;
  logic              exec_req_o;
  logic [ADDR_W-1:0] exec_addr_o;
  logic              exec_ack_i;
  logic [EXIT_W-1:0] exit_code_i;

  int          seed = 18417;
  int          cycle_cnt = 0;
  int          hart_runs = 0;
  logic        idle_chk = 1'b0;
  logic [63:0] exp_entry = '0;
  byte_t       exp_mem [256];
  byte_t       rx_q [$];

  uart_dbg_top uart_dbg_top_inst (
    .clk         ( clk         ),
    .rst_n_i     ( rst_n_i     ),
    .uart_rx_i   ( uart_rx_i   ),
    .uart_tx_o   ( uart_tx_o   ),
    .exec_req_o  ( exec_req_o  ),
    .exec_addr_o ( exec_addr_o ),
    .exec_ack_i  ( exec_ack_i  ),
    .exit_code_i ( exit_code_i )
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////
  // Error reporting
  ////////////////////

  function automatic void fail_value(input string name, input logic [63:0] exp,
                                     input logic [63:0] act);
    $display("FAILED time=%0t signal=%s expected=0x%0h actual=0x%0h", $time, name, exp, act);
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endfunction

  function automatic void fail_msg(input string what);
    $display("ERROR at %0t: %s", $time, what);
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endfunction

  always @(posedge clk) begin : watchdog
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("ERROR at %0t: test did not finish within %0d cycles", $time, cycle_cnt);
      $display("sim failed");
      $fatal(1, "timeout");
    end
  end

  // Quiet line and no hart request before the first command
  assert property (@(posedge clk) disable iff (!idle_chk) uart_tx_o)
    else fail_value("uart_tx_o", 64'(1), 64'(uart_tx_o));
  assert property (@(posedge clk) disable iff (!idle_chk) !exec_req_o)
    else fail_value("exec_req_o", 64'(0), 64'(exec_req_o));

  ////////////////////
  // Line monitor and hart model
  ////////////////////

  // Decodes every frame on uart_tx_o at mid-bit
  initial begin : line_monitor
    byte_t b;
    wait (rst_n_i === 1'b1);
    forever begin
      @(negedge clk);
      if (uart_tx_o === 1'b0) begin
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        assert (uart_tx_o === 1'b0) else fail_msg("start bit on uart_tx_o ended early");
        for (int i = 0; i < DATA_BITS; i++) begin
          repeat (CLKS_PER_BIT) @(negedge clk);
          b[i] = uart_tx_o;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        assert (uart_tx_o === 1'b1)
          else fail_value("uart_tx_o stop bit", 64'(1), 64'(uart_tx_o));
        rx_q.push_back(b);
      end
    end
  end

  always begin : hart_model
    int delay;
    @(negedge clk);
    if (exec_req_o && !exec_ack_i) begin
      assert (exec_addr_o == exp_entry[ADDR_W-1:0])
        else fail_value("exec_addr_o", 64'(exp_entry[ADDR_W-1:0]), 64'(exec_addr_o));
      delay = {$random(seed)} % 21;
      repeat (delay) @(negedge clk);
      exit_code_i = {$random(seed), $random(seed)};
      exec_ack_i  = 1'b1;
      hart_runs++;
      while (exec_req_o) @(negedge clk);
      exec_ack_i = 1'b0;
    end
  end

  ////////////////////
  // Host tasks
  ////////////////////

  // Start, data LSB first, stop, one idle bit
  task automatic send_byte(input byte_t b);
    logic [DATA_BITS+2:0] frame;
    frame = {2'b11, b, 1'b0};
    for (int i = 0; i < DATA_BITS + 3; i++) begin
      uart_rx_i = frame[i];
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
  endtask

  task automatic send_field(input logic [63:0] v);
    for (int i = 0; i < FIELD_BYTES; i++) begin
      send_byte(v[8*i +: 8]);
    end
  endtask

  task automatic recv_byte(output byte_t b);
    while (rx_q.size() == 0) @(negedge clk);
    b = rx_q.pop_front();
  endtask

  task automatic expect_byte(input byte_t exp, input string what);
    byte_t got;
    recv_byte(got);
    assert (got == exp) else fail_value(what, 64'(exp), 64'(got));
  endtask

  task automatic check_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      assert (uart_tx_o === 1'b1) else fail_value("uart_tx_o", 64'(1), 64'(uart_tx_o));
    end
    assert (rx_q.size() == 0) else fail_msg("unexpected reply byte on uart_tx_o");
  endtask

  task automatic write_block(input logic [15:0] addr, input int len);
    byte_t data;
    send_byte(CMD_WRITE);
    send_field({$random(seed), 16'($random(seed)), addr});
    send_field({$random(seed), 16'($random(seed)), 16'(len)});
    expect_byte(REP_ACK, "uart_tx_o WRITE ack");
    for (int i = 0; i < len; i++) begin
      data = 8'($random(seed));
      exp_mem[8'(addr + 16'(i))] = data;
      send_byte(data);
    end
    expect_byte(REP_EOT, "uart_tx_o WRITE eot");
  endtask

  task automatic read_block(input logic [15:0] addr, input int len);
    send_byte(CMD_READ);
    send_field({$random(seed), 16'($random(seed)), addr});
    send_field({$random(seed), 16'($random(seed)), 16'(len)});
    expect_byte(REP_ACK, "uart_tx_o READ ack");
    for (int i = 0; i < len; i++) begin
      expect_byte(exp_mem[8'(addr + 16'(i))], "uart_tx_o READ data");
    end
    expect_byte(REP_EOT, "uart_tx_o READ eot");
  endtask

  task automatic run_exec;
    exp_entry = {$random(seed), $random(seed)};
    send_byte(CMD_EXEC);
    send_field(exp_entry);
    expect_byte(REP_ACK, "uart_tx_o EXEC ack");
    expect_byte(REP_EOC, "uart_tx_o EXEC eoc");
    for (int i = 0; i < EXIT_W / 8; i++) begin
      expect_byte(exit_code_i[8*i +: 8], "uart_tx_o exit code");
    end
    assert (hart_runs == 1) else fail_value("exec_req_o handshakes", 64'(1), 64'(hart_runs));
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin : stimulus
    logic [15:0] addr;
    int          len;
    rst_n_i     = 1'b0;
    uart_rx_i   = 1'b1;
    exec_ack_i  = 1'b0;
    exit_code_i = '0;
    repeat (5) @(negedge clk);
    rst_n_i  = 1'b1;
    idle_chk = 1'b1;
    repeat (2 * FRAME_CYCLES) @(negedge clk);
    idle_chk = 1'b0;

    // Challenge gets exactly one byte back
    send_byte(REP_ACK);
    expect_byte(REP_ACK, "uart_tx_o challenge reply");
    check_quiet(FRAME_CYCLES);

    // First run wraps past address 255
    for (int run = 0; run < NUM_RW_RUNS; run++) begin
      if (run == 0) begin
        addr = {8'($random(seed)), 8'hF8};
        len  = MAX_LEN;
      end else begin
        addr = 16'($random(seed));
        len  = 1 + ({$random(seed)} % MAX_LEN);
      end
      write_block(addr, len);
      read_block(addr, len);
    end

    write_block(16'($random(seed)), 0);
    read_block(16'($random(seed)), 0);

    run_exec();

    // Unknown opcode is dropped silently
    send_byte(8'h55);
    check_quiet(2 * FRAME_CYCLES);
    send_byte(REP_ACK);
    expect_byte(REP_ACK, "uart_tx_o challenge reply");

    $display("sim passed");
    $finish;
  end

endmodule

// ==== vlog.f ====
design/uart_line_pkg.sv
design/dbg_proto_pkg.sv
design/dbg_mem_if.sv
design/uart_rx.sv
design/uart_tx.sv
design/dbg_mem.sv
design/dbg_ctrl.sv
design/uart_dbg_top.sv
dv/tb_uart_dbg.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_uart_dbg
FILELIST  := vlog.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := sim passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
